//--- tests/move_stimulus.txt
# command [argument]: move <dir 0=up 1=down 2=left 3=right>, random <move count>, restart
# random runs stop early at game end, restart first plays on until the game ends
move 2
move 3
move 0
move 1
move 2
move 2
random 40
restart
move 1
move 1
random 60
move 0
restart
random 30
restart
move 3

//--- sources.f
+incdir+design
design/tilePkg.sv
design/ctrlPkg.sv
design/lineMerge.sv
design/moveUnit.sv
design/boardStore.sv
design/spawnPicker.sv
design/statusDetect.sv
design/gameControl.sv
design/game2048Top.sv
tests/game2048Tb.sv

//--- Bender.yml
package:
  name: game2048

sources:
  - include_dirs:
      - design
    files:
      - design/tilePkg.sv
      - design/ctrlPkg.sv
      - design/lineMerge.sv
      - design/moveUnit.sv
      - design/boardStore.sv
      - design/spawnPicker.sv
      - design/statusDetect.sv
      - design/gameControl.sv
      - design/game2048Top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/game2048Tb.sv

//--- tests/game2048Tb.sv
`timescale 1ns/1ns
`include "game2048_defines.svh"

module game2048Tb;

	localparam int ackTimeout = 100;
	localparam int openTimeout = 100;
	localparam int ignoreCycles = 40;
	localparam int maxGameMoves = 3000;

	logic clk;
	logic rst;
	logic moveReq;
	ctrlPkg::moveDirT moveDir;
	logic restart;
	logic moveAck;
	tilePkg::boardT board;
	logic gameWon;
	logic gameLost;

	logic [31:0] rndState;
	int fd;
	int code;
	int arg;
	string cmd;
	string rest;

	game2048Top dut (
		.clk     (clk),
		.rst     (rst),
		.moveReq (moveReq),
		.moveDir (moveDir),
		.restart (restart),
		.moveAck (moveAck),
		.board   (board),
		.gameWon (gameWon),
		.gameLost(gameLost)
	);

	always #10 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
			abortRun($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
				testName, expected, actual));
	endtask

	// Inputs change and outputs are read 2 ns after the rising edge
	task automatic stepCycle();
		@(posedge clk);
		#2;
	endtask

	// Reference slide of one line toward entry 0
	function automatic tilePkg::lineT mergeModel(input tilePkg::lineT line);
		tilePkg::lineT result;
		int n;
		logic canMerge;
		result = '0;
		n = 0;
		canMerge = 1'b0;
		for (int i = 0; i < `GRID_SIDE; i++)
		begin
			if (line[i] != 0)
			begin
				if (canMerge && result[n-1] == line[i])
				begin
					result[n-1] = line[i] + 1;
					canMerge = 1'b0;
				end
				else
				begin
					result[n] = line[i];
					n++;
					canMerge = 1'b1;
				end
			end
		end
		return result;
	endfunction

	function automatic tilePkg::boardT slideModel(input tilePkg::boardT b,
		input ctrlPkg::moveDirT dir);
		tilePkg::boardT result;
		tilePkg::lineT line;
		int cells [`GRID_SIDE];
		result = '0;
		for (int k = 0; k < `GRID_SIDE; k++)
		begin
			for (int p = 0; p < `GRID_SIDE; p++)
			begin
				case (dir)
					ctrlPkg::dirUp: cells[p] = p * `GRID_SIDE + k;
					ctrlPkg::dirDown: cells[p] = (`GRID_SIDE - 1 - p) * `GRID_SIDE + k;
					ctrlPkg::dirLeft: cells[p] = k * `GRID_SIDE + p;
					default: cells[p] = k * `GRID_SIDE + (`GRID_SIDE - 1 - p);
				endcase
				line[p] = b[cells[p]];
			end
			line = mergeModel(line);
			for (int p = 0; p < `GRID_SIDE; p++)
				result[cells[p]] = line[p];
		end
		return result;
	endfunction

	function automatic logic modelWon(input tilePkg::boardT b);
		for (int i = 0; i < `CELL_COUNT; i++)
			if (b[i] == `WIN_EXP)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic modelLost(input tilePkg::boardT b);
		for (int i = 0; i < `CELL_COUNT; i++)
		begin
			if (b[i] == 0)
				return 1'b0;
			if (i % `GRID_SIDE != `GRID_SIDE - 1 && b[i] == b[i+1])
				return 1'b0;
			if (i + `GRID_SIDE < `CELL_COUNT && b[i] == b[i+`GRID_SIDE])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic int countTiles(input tilePkg::boardT b, input int value);
		int n;
		n = 0;
		for (int i = 0; i < `CELL_COUNT; i++)
			if ((value < 0 && b[i] != 0) || b[i] == value)
				n++;
		return n;
	endfunction

	// LCG step with the direction taken from the top bits
	function automatic ctrlPkg::moveDirT nextDir();
		rndState = rndState * 32'd1664525 + 32'd1013904223;
		return ctrlPkg::moveDirT'(rndState[31:30]);
	endfunction

	task automatic waitOpening(input string when);
		int waited;
		waited = 0;
		while (countTiles(board, -1) != 2 && waited < openTimeout)
		begin
			stepCycle();
			waited++;
		end
		if (countTiles(board, -1) != 2)
			abortRun($sformatf("Timed out waiting for the two opening tiles after %s", when));
		checkValue({when, " opening tiles"}, 2, countTiles(board, `SPAWN_EXP));
		checkValue({when, " gameWon low"}, 0, gameWon);
		checkValue({when, " gameLost low"}, 0, gameLost);
	endtask

	// A finished game must ignore moves
	task automatic checkIgnored(input ctrlPkg::moveDirT dir);
		tilePkg::boardT held;
		held = board;
		moveDir = dir;
		moveReq = 1'b1;
		for (int i = 0; i < ignoreCycles; i++)
		begin
			stepCycle();
			if (moveAck)
				abortRun("A move was acknowledged after the game ended");
			checkValue("board frozen after game end", held, board);
		end
		moveReq = 1'b0;
		stepCycle();
	endtask

	task automatic doMove(input ctrlPkg::moveDirT dir);
		tilePkg::boardT boardBefore;
		tilePkg::boardT slid;
		tilePkg::boardT boardAfter;
		int waited;
		int diffs;
		int spawnAt;
		logic expWon;
		logic expLost;
		if (gameWon || gameLost)
		begin
			checkIgnored(dir);
		end
		else
		begin
			boardBefore = board;
			slid = slideModel(boardBefore, dir);
			expWon = modelWon(slid);
			expLost = modelLost(slid);
			moveDir = dir;
			moveReq = 1'b1;
			waited = 0;
			while (!moveAck && waited < ackTimeout)
			begin
				stepCycle();
				waited++;
			end
			if (!moveAck)
				abortRun("Timed out waiting for moveAck to rise");
			boardAfter = board;
			if (slid == boardBefore || expWon || expLost)
			begin
				checkValue("board without spawn", slid, boardAfter);
			end
			else
			begin
				diffs = 0;
				spawnAt = 0;
				for (int i = 0; i < `CELL_COUNT; i++)
				begin
					if (slid[i] != boardAfter[i])
					begin
						diffs++;
						spawnAt = i;
					end
				end
				checkValue("one new tile", 1, diffs);
				checkValue("new tile on empty cell", 0, slid[spawnAt]);
				checkValue("new tile value", `SPAWN_EXP, boardAfter[spawnAt]);
			end
			moveReq = 1'b0;
			waited = 0;
			while (moveAck && waited < ackTimeout)
			begin
				stepCycle();
				waited++;
			end
			if (moveAck)
				abortRun("Timed out waiting for moveAck to fall");
			checkValue("gameWon after move", expWon, gameWon);
			checkValue("gameLost after move", expLost, gameLost);
			if (gameWon || gameLost)
				checkIgnored(dir);
		end
	endtask

	task automatic playRandom(input int count);
		ctrlPkg::moveDirT dir;
		for (int i = 0; i < count && !gameWon && !gameLost; i++)
		begin
			dir = nextDir();
			doMove(dir);
		end
	endtask

	task automatic restartGame();
		playRandom(maxGameMoves);
		if (!gameWon && !gameLost)
			abortRun("The game did not end within the move limit before restart");
		restart = 1'b1;
		stepCycle();
		checkValue("moveAck low at restart", 0, moveAck);
		restart = 1'b0;
		waitOpening("restart");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		moveReq = 1'b0;
		moveDir = ctrlPkg::dirUp;
		restart = 1'b0;
		rndState = 32'ha649;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		waitOpening("reset");

		fd = $fopen("tests/move_stimulus.txt", "r");
		if (fd == 0)
			abortRun("Could not open the stimulus file tests/move_stimulus.txt");
		code = $fscanf(fd, "%s", cmd);
		while (code == 1)
		begin
			if (cmd.getc(0) == "#")
				code = $fgets(rest, fd);
			else if (cmd == "restart")
				restartGame();
			else if (cmd == "move" || cmd == "random")
			begin
				if ($fscanf(fd, "%d", arg) != 1)
					abortRun($sformatf("Missing argument after %s in stimulus file", cmd));
				if (cmd == "move")
					doMove(ctrlPkg::moveDirT'(arg));
				else
					playRandom(arg);
			end
			else
				abortRun($sformatf("Unknown stimulus command %s", cmd));
			code = $fscanf(fd, "%s", cmd);
		end
		$fclose(fd);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- design/game2048Top.sv
`timescale 1ns/1ns

module game2048Top (
	input  logic              clk,
	input  logic              rst,
	input  logic              moveReq,
	input  ctrlPkg::moveDirT  moveDir,
	input  logic              restart,
	output logic              moveAck,
	output tilePkg::boardT    board,
	output logic              gameWon,
	output logic              gameLost
);

	logic clearBoard;
	logic loadMove;
	logic placeTile;
	tilePkg::cellT spawnCell;
	logic spawnFree;
	tilePkg::boardT movedBoard;
	logic changed;
	logic won;
	logic lost;

	gameControl control (
		.clk       (clk),
		.rst       (rst),
		.moveReq   (moveReq),
		.restart   (restart),
		.spawnFree (spawnFree),
		.changed   (changed),
		.won       (won),
		.lost      (lost),
		.moveAck   (moveAck),
		.clearBoard(clearBoard),
		.loadMove  (loadMove),
		.placeTile (placeTile),
		.gameWon   (gameWon),
		.gameLost  (gameLost)
	);

	spawnPicker picker (
		.clk      (clk),
		.rst      (rst),
		.board    (board),
		.spawnCell(spawnCell),
		.spawnFree(spawnFree)
	);

	boardStore store (
		.clk       (clk),
		.rst       (rst),
		.clearBoard(clearBoard),
		.loadMove  (loadMove),
		.placeTile (placeTile),
		.movedBoard(movedBoard),
		.placeCell (spawnCell),
		.board     (board)
	);

	moveUnit mover (
		.boardIn (board),
		.moveDir (moveDir),
		.boardOut(movedBoard),
		.changed (changed)
	);

	// Judges the board as it will be after the move
	statusDetect movedStatus (
		.board(movedBoard),
		.won  (won),
		.lost (lost)
	);

endmodule

//--- design/gameControl.sv
`timescale 1ns/1ns

module gameControl (
	input  logic clk,
	input  logic rst,
	input  logic moveReq,
	input  logic restart,
	input  logic spawnFree,
	input  logic changed,
	input  logic won,
	input  logic lost,
	output logic moveAck,
	output logic clearBoard,
	output logic loadMove,
	output logic placeTile,
	output logic gameWon,
	output logic gameLost
);

	ctrlPkg::gameStateT state;
	ctrlPkg::gameStateT stateNext;
	logic openingSpawn;
	logic wonHit;
	logic lostHit;

	always_comb
	begin
		stateNext = state;
		case (state)
			ctrlPkg::stInit:
				stateNext = ctrlPkg::stSpawn;
			ctrlPkg::stSpawn:
			begin
				if (spawnFree && openingSpawn)
					stateNext = ctrlPkg::stIdle;
				else if (spawnFree)
					stateNext = ctrlPkg::stAck;
			end
			ctrlPkg::stIdle:
			begin
				if (moveReq)
					stateNext = ctrlPkg::stMove;
			end
			ctrlPkg::stMove:
			begin
				// No spawn after a dead move or a finished game
				if (!changed || won || lost)
					stateNext = ctrlPkg::stAck;
				else
					stateNext = ctrlPkg::stSpawn;
			end
			ctrlPkg::stAck:
			begin
				if (!moveReq && (wonHit || lostHit))
					stateNext = ctrlPkg::stOver;
				else if (!moveReq)
					stateNext = ctrlPkg::stIdle;
			end
			ctrlPkg::stOver:
			begin
				if (restart)
					stateNext = ctrlPkg::stInit;
			end
			default:
				stateNext = ctrlPkg::stInit;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ctrlPkg::stInit;
			openingSpawn <= 1'b0;
			wonHit <= 1'b0;
			lostHit <= 1'b0;
			gameWon <= 1'b0;
			gameLost <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			if (state == ctrlPkg::stInit)
			begin
				openingSpawn <= 1'b1;
				wonHit <= 1'b0;
				lostHit <= 1'b0;
				gameWon <= 1'b0;
				gameLost <= 1'b0;
			end
			if (state == ctrlPkg::stSpawn && spawnFree)
				openingSpawn <= 1'b0;
			// Outcome of the moved board, before any spawn
			if (state == ctrlPkg::stMove)
			begin
				wonHit <= won;
				lostHit <= lost;
			end
			if (state == ctrlPkg::stAck && stateNext == ctrlPkg::stOver)
			begin
				gameWon <= wonHit;
				gameLost <= lostHit;
			end
		end
	end

	assign moveAck = (state == ctrlPkg::stAck);
	assign clearBoard = (state == ctrlPkg::stInit);
	assign loadMove = (state == ctrlPkg::stMove);
	// First tile goes straight into the cleared board
	assign placeTile = (state == ctrlPkg::stInit) || (state == ctrlPkg::stSpawn && spawnFree);

endmodule

//--- design/statusDetect.sv
`timescale 1ns/1ns
`include "game2048_defines.svh"

module statusDetect (
	input  tilePkg::boardT board,
	output logic           won,
	output logic           lost
);

	logic full;
	logic pairFound;

	always_comb
	begin
		won = 1'b0;
		full = 1'b1;
		pairFound = 1'b0;
		for (int r = 0; r < `GRID_SIDE; r++)
		begin
			for (int c = 0; c < `GRID_SIDE; c++)
			begin
				if (board[r*`GRID_SIDE + c] == tilePkg::tileT'(`WIN_EXP))
					won = 1'b1;
				if (board[r*`GRID_SIDE + c] == '0)
					full = 1'b0;
				// Right neighbor
				if (c < `GRID_SIDE - 1)
				begin
					if (board[r*`GRID_SIDE + c] == board[r*`GRID_SIDE + c + 1])
						pairFound = 1'b1;
				end
				// Neighbor below
				if (r < `GRID_SIDE - 1)
				begin
					if (board[r*`GRID_SIDE + c] == board[(r+1)*`GRID_SIDE + c])
						pairFound = 1'b1;
				end
			end
		end
	end

	assign lost = full && !pairFound;

endmodule

//--- design/spawnPicker.sv
`timescale 1ns/1ns

module spawnPicker (
	input  logic            clk,
	input  logic            rst,
	input  tilePkg::boardT  board,
	output tilePkg::cellT   spawnCell,
	output logic            spawnFree
);

	// Free-running, so the cell depends on when the player moves
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			spawnCell <= '0;
		end
		else
		begin
			spawnCell <= tilePkg::cellT'(spawnCell + 1'b1);
		end
	end

	assign spawnFree = (board[spawnCell] == '0);

endmodule

//--- design/boardStore.sv
`timescale 1ns/1ns
`include "game2048_defines.svh"

module boardStore (
	input  logic            clk,
	input  logic            rst,
	input  logic            clearBoard,
	input  logic            loadMove,
	input  logic            placeTile,
	input  tilePkg::boardT  movedBoard,
	input  tilePkg::cellT   placeCell,
	output tilePkg::boardT  board
);

	tilePkg::boardT boardNext;

	always_comb
	begin
		boardNext = board;
		if (clearBoard)
		begin
			boardNext = '0;
		end
		else if (loadMove)
		begin
			boardNext = movedBoard;
		end
		// Placement lands on top of a clear in the same cycle
		if (placeTile)
		begin
			boardNext[placeCell] = tilePkg::tileT'(`SPAWN_EXP);
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			board <= '0;
		end
		else
		begin
			board <= boardNext;
		end
	end

endmodule

//--- design/moveUnit.sv
`timescale 1ns/1ns
`include "game2048_defines.svh"

module moveUnit (
	input  tilePkg::boardT    boardIn,
	input  ctrlPkg::moveDirT  moveDir,
	output tilePkg::boardT    boardOut,
	output logic              changed
);

	tilePkg::lineT gathered [`GRID_SIDE];
	tilePkg::lineT merged [`GRID_SIDE];

	// Board cell of position pos in line number line under a move direction
	function automatic tilePkg::cellT cellOf(
		input ctrlPkg::moveDirT dir,
		input int line,
		input int pos
	);
		int row;
		int col;
		case (dir)
			ctrlPkg::dirUp:
			begin
				row = pos;
				col = line;
			end
			ctrlPkg::dirDown:
			begin
				row = `GRID_SIDE - 1 - pos;
				col = line;
			end
			ctrlPkg::dirLeft:
			begin
				row = line;
				col = pos;
			end
			default:
			begin
				row = line;
				col = `GRID_SIDE - 1 - pos;
			end
		endcase
		return tilePkg::cellT'(row * `GRID_SIDE + col);
	endfunction

	always_comb
	begin
		for (int k = 0; k < `GRID_SIDE; k++)
		begin
			for (int p = 0; p < `GRID_SIDE; p++)
				gathered[k][p] = boardIn[cellOf(moveDir, k, p)];
		end
	end

	for (genvar k = 0; k < `GRID_SIDE; k++)
	begin : gLine
		lineMerge merger (
			.lineIn (gathered[k]),
			.lineOut(merged[k])
		);
	end

	// Same mapping back so every cell is written exactly once
	always_comb
	begin
		boardOut = '0;
		for (int k = 0; k < `GRID_SIDE; k++)
		begin
			for (int p = 0; p < `GRID_SIDE; p++)
				boardOut[cellOf(moveDir, k, p)] = merged[k][p];
		end
	end

	assign changed = (boardOut != boardIn);

endmodule

//--- design/lineMerge.sv
`timescale 1ns/1ns
`include "game2048_defines.svh"

module lineMerge (
	input  tilePkg::lineT lineIn,
	output tilePkg::lineT lineOut
);

	tilePkg::lineT packedLine;
	tilePkg::lineT mergedLine;

	// Shift nonzero tiles to the front, keeping their order
	function automatic tilePkg::lineT packLine(input tilePkg::lineT line);
		tilePkg::lineT result;
		int slot;
		result = '0;
		slot = 0;
		for (int i = 0; i < `GRID_SIDE; i++)
		begin
			if (line[i] != '0)
			begin
				result[slot] = line[i];
				slot++;
			end
		end
		return result;
	endfunction

	assign packedLine = packLine(lineIn);

	// Front-first pair scan
	always_comb
	begin
		mergedLine = packedLine;
		for (int i = 0; i < `GRID_SIDE - 1; i++)
		begin
			if (mergedLine[i] != '0 && mergedLine[i] == mergedLine[i+1])
			begin
				mergedLine[i] = tilePkg::tileT'(mergedLine[i] + 1'b1);
				// Cleared partner cannot merge again
				mergedLine[i+1] = '0;
			end
		end
	end

	// Close the gaps left by merges
	assign lineOut = packLine(mergedLine);

endmodule

//--- design/ctrlPkg.sv
package ctrlPkg;

	typedef enum logic [1:0] {
		dirUp    = 2'd0,
		dirDown  = 2'd1,
		dirLeft  = 2'd2,
		dirRight = 2'd3
	} moveDirT;

	typedef enum logic [2:0] {
		stInit  = 3'd0,
		stSpawn = 3'd1,
		stIdle  = 3'd2,
		stMove  = 3'd3,
		stAck   = 3'd4,
		stOver  = 3'd5
	} gameStateT;

endpackage

//--- design/tilePkg.sv
`include "game2048_defines.svh"

package tilePkg;

	// One exponent, zero when the cell is empty
	typedef logic [`TILE_BITS-1:0] tileT;

	// Entry 0 is the cell the line slides toward
	typedef tileT [`GRID_SIDE-1:0] lineT;

	// Cell index is row * GRID_SIDE + column
	typedef tileT [`CELL_COUNT-1:0] boardT;

	typedef logic [$clog2(`CELL_COUNT)-1:0] cellT;

endpackage

//--- design/game2048_defines.svh
`ifndef GAME2048_DEFINES_SVH
`define GAME2048_DEFINES_SVH

// Board geometry
`define GRID_SIDE 4
`define CELL_COUNT 16

// Tiles hold exponents, 0 is an empty cell
`define TILE_BITS 4

// Exponent 8 is the 256 tile
`define WIN_EXP 8

// New tiles are always a 2
`define SPAWN_EXP 1

`endif
